/* src/pcs_rx_pkg.sv */
package pcs_rx_pkg;

    // Basic widths
    typedef logic [31:0] xgmii_data_t;
    typedef logic [3:0]  xgmii_ctl_t;
    typedef logic [1:0]  sync_hdr_t;
    typedef logic [7:0]  block_type_t;
    typedef logic [7:0]  err_count_t;

    // Sync header values
    localparam sync_hdr_t SYNC_DATA = 2'b01;
    localparam sync_hdr_t SYNC_CTRL = 2'b10;

    // XGMII control characters
    localparam logic [7:0] RS_IDLE  = 8'h07;
    localparam logic [7:0] RS_START = 8'hFB;
    localparam logic [7:0] RS_TERM  = 8'hFD;
    localparam logic [7:0] RS_ERROR = 8'hFE;

    // Supported 64b/66b block types
    localparam block_type_t BT_IDLE  = 8'h1E;
    localparam block_type_t BT_START = 8'h78;
    localparam block_type_t BT_TERM0 = 8'h87;
    localparam block_type_t BT_TERM1 = 8'h99;
    localparam block_type_t BT_TERM2 = 8'hAA;
    localparam block_type_t BT_TERM3 = 8'hB4;
    localparam block_type_t BT_TERM4 = 8'hCC;
    localparam block_type_t BT_TERM5 = 8'hD2;
    localparam block_type_t BT_TERM6 = 8'hE1;
    localparam block_type_t BT_TERM7 = 8'hFF;

    // Lock thresholds, counted in sync headers
    localparam int LOCK_GOOD_HDRS  = 64;
    localparam int UNLOCK_BAD_HDRS = 16;
    localparam int SLIP_WAIT_HDRS  = 16;

    // Descrambled word on its way to the decoder
    typedef struct packed {
        xgmii_data_t data;
        sync_hdr_t   header;
        logic        data_valid;
        logic        header_valid;
    } rx_word_t;

    // Decoded XGMII word
    typedef struct packed {
        xgmii_data_t data;
        xgmii_ctl_t  ctl;
        logic        valid;
        xgmii_ctl_t  term_loc;
    } xgmii_rx_t;

    typedef enum logic [1:0] {
        LS_HUNT,
        LS_SLIP_WAIT,
        LS_LOCKED
    } lock_state_e;

endpackage

/* src/pcs_rx_lock_state.sv */
`timescale 1ns/100ps

module pcs_rx_lock_state (
    input  logic                  i_xver_rx_clk,
    input  logic                  i_rx_reset,
    input  pcs_rx_pkg::sync_hdr_t i_header,
    input  logic                  i_header_valid,
    output logic                  o_slip,
    output logic                  o_block_lock
);

    import pcs_rx_pkg::*;

    localparam int WINDOW_HDRS = 64;
    localparam int CNT_W       = $clog2(WINDOW_HDRS) + 1;

    lock_state_e      state_q;
    logic [CNT_W-1:0] good_cnt_q;
    logic [CNT_W-1:0] win_cnt_q;
    logic [CNT_W-1:0] bad_cnt_q;
    logic             slip_q;
    logic             hdr_good;

    // Only 01 and 10 are legal sync headers
    assign hdr_good = (i_header == SYNC_DATA) || (i_header == SYNC_CTRL);

    always_ff @(posedge i_xver_rx_clk) begin
        if (i_rx_reset) begin
            state_q    <= LS_HUNT;
            good_cnt_q <= '0;
            win_cnt_q  <= '0;
            bad_cnt_q  <= '0;
            slip_q     <= 1'b0;
        end else begin
            slip_q <= 1'b0;
            if (i_header_valid) begin
                case (state_q)
                    LS_HUNT: begin
                        if (!hdr_good) begin
                            // Wrong alignment, ask the gearbox to move one bit
                            slip_q     <= 1'b1;
                            state_q    <= LS_SLIP_WAIT;
                            good_cnt_q <= '0;
                            win_cnt_q  <= '0;
                        end else if (good_cnt_q == CNT_W'(LOCK_GOOD_HDRS - 1)) begin
                            state_q    <= LS_LOCKED;
                            good_cnt_q <= '0;
                            win_cnt_q  <= '0;
                            bad_cnt_q  <= '0;
                        end else begin
                            good_cnt_q <= good_cnt_q + 1'b1;
                        end
                    end

                    LS_SLIP_WAIT: begin
                        // Let the slipped alignment settle before judging it
                        if (win_cnt_q == CNT_W'(SLIP_WAIT_HDRS - 1)) begin
                            state_q    <= LS_HUNT;
                            good_cnt_q <= '0;
                            win_cnt_q  <= '0;
                        end else begin
                            win_cnt_q <= win_cnt_q + 1'b1;
                        end
                    end

                    LS_LOCKED: begin
                        if (!hdr_good && bad_cnt_q == CNT_W'(UNLOCK_BAD_HDRS - 1)) begin
                            // Too many bad headers in this window
                            slip_q    <= 1'b1;
                            state_q   <= LS_SLIP_WAIT;
                            win_cnt_q <= '0;
                            bad_cnt_q <= '0;
                        end else if (win_cnt_q == CNT_W'(WINDOW_HDRS - 1)) begin
                            // Window done, start a fresh one
                            win_cnt_q <= '0;
                            bad_cnt_q <= '0;
                        end else begin
                            win_cnt_q <= win_cnt_q + 1'b1;
                            if (!hdr_good) begin
                                bad_cnt_q <= bad_cnt_q + 1'b1;
                            end
                        end
                    end

                    default: begin
                        state_q <= LS_HUNT;
                    end
                endcase
            end
        end
    end

    assign o_slip       = slip_q;
    assign o_block_lock = (state_q == LS_LOCKED);

endmodule

/* src/pcs_rx_descrambler.sv */
`timescale 1ns/100ps

module pcs_rx_descrambler #(
    parameter bit SCRAMBLER_BYPASS = 1'b0
) (
    input  logic                    i_xver_rx_clk,
    input  logic                    i_rx_reset,
    input  pcs_rx_pkg::xgmii_data_t i_data,
    input  pcs_rx_pkg::sync_hdr_t   i_header,
    input  logic                    i_data_valid,
    input  logic                    i_header_valid,
    output pcs_rx_pkg::rx_word_t    o_word
);

    import pcs_rx_pkg::*;

    localparam int POLY_LEN = 58;
    localparam int TAP      = 39;
    localparam int W        = $bits(xgmii_data_t);

    // hist_q[POLY_LEN-1] is the most recently received scrambled bit
    logic [POLY_LEN-1:0]   hist_q;
    logic [POLY_LEN+W-1:0] stream;
    xgmii_data_t           descr;

    xgmii_data_t data_q;
    sync_hdr_t   hdr_q;
    logic        dv_q;
    logic        hv_q;

    // Bit i of the word sits at stream[POLY_LEN+i], so s39 and s58 are
    // always inside the stored history for a 32-bit word
    assign stream = {i_data, hist_q};
    assign descr  = i_data ^ stream[POLY_LEN-TAP +: W] ^ stream[0 +: W];

    // History moves only on valid words, so a gearbox pause freezes it
    always_ff @(posedge i_xver_rx_clk) begin
        if (i_data_valid) begin
            hist_q <= stream[W +: POLY_LEN];
        end
    end

    always_ff @(posedge i_xver_rx_clk) begin
        data_q <= SCRAMBLER_BYPASS ? i_data : descr;
        hdr_q  <= i_header;
    end

    always_ff @(posedge i_xver_rx_clk) begin
        if (i_rx_reset) begin
            dv_q <= 1'b0;
            hv_q <= 1'b0;
        end else begin
            dv_q <= i_data_valid;
            hv_q <= i_header_valid && i_data_valid;
        end
    end

    assign o_word = '{data: data_q, header: hdr_q, data_valid: dv_q, header_valid: hv_q};

endmodule

/* src/pcs_rx_decoder.sv */
`timescale 1ns/100ps

module pcs_rx_decoder (
    input  logic                  i_xver_rx_clk,
    input  logic                  i_rx_reset,
    input  pcs_rx_pkg::rx_word_t  i_word,
    output pcs_rx_pkg::xgmii_rx_t o_xgmii,
    output logic                  o_blk_err
);

    import pcs_rx_pkg::*;

    localparam int NBYTES = $bits(xgmii_ctl_t);

    // Terminate lane for a block type, 8 when the type has none
    function automatic logic [3:0] term_lane(block_type_t bt);
        case (bt)
            BT_TERM0: term_lane = 4'd0;
            BT_TERM1: term_lane = 4'd1;
            BT_TERM2: term_lane = 4'd2;
            BT_TERM3: term_lane = 4'd3;
            BT_TERM4: term_lane = 4'd4;
            BT_TERM5: term_lane = 4'd5;
            BT_TERM6: term_lane = 4'd6;
            BT_TERM7: term_lane = 4'd7;
            default:  term_lane = 4'd8;
        endcase
    endfunction

    sync_hdr_t   hdr_q;
    block_type_t type_q;
    logic        second_q;

    logic        first_word;
    logic        second_word;
    sync_hdr_t   cur_hdr;
    block_type_t cur_type;
    logic [3:0]  term_pos;
    logic        type_ok;
    logic        blk_bad;
    xgmii_data_t term_src;
    logic [3:0]  lane;
    xgmii_data_t dec_data;
    xgmii_ctl_t  dec_ctl;
    xgmii_ctl_t  term_loc;

    xgmii_data_t data_q;
    xgmii_ctl_t  ctl_q;
    logic        valid_q;
    xgmii_ctl_t  term_q;
    logic        blk_err_q;

    assign first_word  = i_word.data_valid && i_word.header_valid;
    assign second_word = i_word.data_valid && !i_word.header_valid;

    // Second word decodes against what the first word left behind
    assign cur_hdr  = first_word ? i_word.header : hdr_q;
    assign cur_type = first_word ? i_word.data[7:0] : type_q;
    assign term_pos = term_lane(cur_type);
    assign type_ok  = (cur_type == BT_IDLE) || (cur_type == BT_START) || (term_pos != 4'd8);

    // Bad header, unknown type, or a second word with no first word
    assign blk_bad = !((cur_hdr == SYNC_DATA) || (cur_hdr == SYNC_CTRL))
                     || ((cur_hdr == SYNC_CTRL) && !type_ok)
                     || (second_word && !second_q);

    // Data ahead of a terminate starts one byte up, after the type byte.
    // For T4..T7 lane 3 would need the next word's first byte and reads zero
    assign term_src = {8'h00, i_word.data[31:8]};

    always_comb begin
        lane     = '0;
        dec_data = i_word.data;
        dec_ctl  = '0;
        if (blk_bad) begin
            dec_data = {NBYTES{RS_ERROR}};
            dec_ctl  = '1;
        end else if (cur_hdr == SYNC_CTRL) begin
            for (int i = 0; i < NBYTES; i++) begin
                lane = first_word ? 4'(i) : 4'(i + NBYTES);
                if (cur_type == BT_IDLE) begin
                    dec_data[i*8 +: 8] = RS_IDLE;
                    dec_ctl[i]         = 1'b1;
                end else if (cur_type == BT_START) begin
                    // Data bytes already sit in their own lanes
                    if (lane == 4'd0) begin
                        dec_data[i*8 +: 8] = RS_START;
                        dec_ctl[i]         = 1'b1;
                    end
                end else if (lane < term_pos) begin
                    dec_data[i*8 +: 8] = term_src[i*8 +: 8];
                end else if (lane == term_pos) begin
                    dec_data[i*8 +: 8] = RS_TERM;
                    dec_ctl[i]         = 1'b1;
                end else begin
                    dec_data[i*8 +: 8] = RS_IDLE;
                    dec_ctl[i]         = 1'b1;
                end
            end
        end
    end

    // Early terminate flags for the MAC
    always_comb begin
        for (int i = 0; i < NBYTES; i++) begin
            term_loc[i] = i_word.data_valid && dec_ctl[i] && (dec_data[i*8 +: 8] == RS_TERM);
        end
    end

    always_ff @(posedge i_xver_rx_clk) begin
        if (first_word) begin
            hdr_q  <= i_word.header;
            type_q <= i_word.data[7:0];
        end
        data_q <= dec_data;
        ctl_q  <= dec_ctl;
    end

    always_ff @(posedge i_xver_rx_clk) begin
        if (i_rx_reset) begin
            second_q  <= 1'b0;
            valid_q   <= 1'b0;
            term_q    <= '0;
            blk_err_q <= 1'b0;
        end else begin
            if (first_word) begin
                second_q <= 1'b1;
            end else if (second_word) begin
                second_q <= 1'b0;
            end
            valid_q   <= i_word.data_valid;
            term_q    <= term_loc;
            blk_err_q <= second_word && blk_bad;
        end
    end

    assign o_xgmii   = '{data: data_q, ctl: ctl_q, valid: valid_q, term_loc: term_q};
    assign o_blk_err = blk_err_q;

endmodule

/* src/pcs_rx_block_err_counter.sv */
`timescale 1ns/100ps

module pcs_rx_block_err_counter (
    input  logic                   i_xver_rx_clk,
    input  logic                   i_rx_reset,
    input  logic                   i_blk_err,
    input  logic                   i_block_lock,
    output pcs_rx_pkg::err_count_t o_count
);

    import pcs_rx_pkg::*;

    err_count_t count_q;
    logic       count_full;

    // Sticks at the top value instead of wrapping
    assign count_full = &count_q;

    always_ff @(posedge i_xver_rx_clk) begin
        if (i_rx_reset) begin
            count_q <= '0;
        end else if (i_blk_err && i_block_lock && !count_full) begin
            // Errors while hunting are expected and not counted
            count_q <= count_q + 1'b1;
        end
    end

    assign o_count = count_q;

endmodule

/* src/pcs_rx.sv */
`timescale 1ns/100ps

module pcs_rx #(
    parameter bit SCRAMBLER_BYPASS = 1'b0
) (
    input  logic                    i_xver_rx_clk,
    input  logic                    i_rx_reset,

    // From the transceiver gearbox
    input  pcs_rx_pkg::xgmii_data_t i_xver_rx_data,
    input  pcs_rx_pkg::sync_hdr_t   i_xver_rx_header,
    input  logic                    i_xver_rx_data_valid,
    input  logic                    i_xver_rx_header_valid,
    output logic                    o_xver_rx_gearbox_slip,

    // Status
    output logic                    o_block_lock,
    output pcs_rx_pkg::err_count_t  o_errored_blocks,

    // XGMII receive side, valid is non-standard
    output pcs_rx_pkg::xgmii_data_t o_xgmii_rx_data,
    output pcs_rx_pkg::xgmii_ctl_t  o_xgmii_rx_ctl,
    output logic                    o_xgmii_rx_valid,
    output pcs_rx_pkg::xgmii_ctl_t  o_term_loc
);

    import pcs_rx_pkg::*;

    rx_word_t  desc_word;
    xgmii_rx_t xgmii;
    logic      block_lock;
    logic      blk_err;

    // Lock works on the raw headers, ahead of the datapath
    pcs_rx_lock_state u_lock_state (
        .i_xver_rx_clk  (i_xver_rx_clk),
        .i_rx_reset     (i_rx_reset),
        .i_header       (i_xver_rx_header),
        .i_header_valid (i_xver_rx_header_valid),
        .o_slip         (o_xver_rx_gearbox_slip),
        .o_block_lock   (block_lock)
    );

    pcs_rx_descrambler #(
        .SCRAMBLER_BYPASS (SCRAMBLER_BYPASS)
    ) u_descrambler (
        .i_xver_rx_clk  (i_xver_rx_clk),
        .i_rx_reset     (i_rx_reset),
        .i_data         (i_xver_rx_data),
        .i_header       (i_xver_rx_header),
        .i_data_valid   (i_xver_rx_data_valid),
        .i_header_valid (i_xver_rx_header_valid),
        .o_word         (desc_word)
    );

    pcs_rx_decoder u_decoder (
        .i_xver_rx_clk (i_xver_rx_clk),
        .i_rx_reset    (i_rx_reset),
        .i_word        (desc_word),
        .o_xgmii       (xgmii),
        .o_blk_err     (blk_err)
    );

    pcs_rx_block_err_counter u_block_err_counter (
        .i_xver_rx_clk (i_xver_rx_clk),
        .i_rx_reset    (i_rx_reset),
        .i_blk_err     (blk_err),
        .i_block_lock  (block_lock),
        .o_count       (o_errored_blocks)
    );

    assign o_block_lock     = block_lock;
    assign o_xgmii_rx_data  = xgmii.data;
    assign o_xgmii_rx_ctl   = xgmii.ctl;
    assign o_xgmii_rx_valid = xgmii.valid;
    assign o_term_loc       = xgmii.term_loc;

endmodule

/* tests/pcs_rx_model.svh */
`ifndef PCS_RX_MODEL_SVH
`define PCS_RX_MODEL_SVH

typedef enum int {K_DATA, K_IDLE, K_START, K_TERM, K_BAD_TYPE, K_BAD_HDR} blk_kind_e;

// Transmit scrambler history, bit 0 is the newest scrambled bit
logic [57:0] scr_q;

// Expected XGMII words, oldest first
xgmii_data_t exp_data_q[$];
xgmii_ctl_t  exp_ctl_q[$];
xgmii_ctl_t  exp_term_q[$];

lock_state_e m_state;
int          m_good;
int          m_win;
int          m_bad;
logic        exp_slip;
logic        exp_lock;
int          exp_slips;
err_count_t  exp_errs;

task automatic model_reset();
    logic [63:0] r;
    r         = {$random(seed), $random(seed)};
    scr_q     = r[57:0];
    m_state   = LS_HUNT;
    m_good    = 0;
    m_win     = 0;
    m_bad     = 0;
    exp_slip  = 1'b0;
    exp_lock  = 1'b0;
    exp_slips = 0;
    exp_errs  = '0;
endtask

// x^58 + x^39 + 1, LSB first
task automatic scramble_word(input xgmii_data_t d, output xgmii_data_t s);
    for (int i = 0; i < 32; i++) begin
        s[i]  = d[i] ^ scr_q[38] ^ scr_q[57];
        scr_q = {scr_q[56:0], s[i]};
    end
endtask

function automatic block_type_t term_type(input int k);
    block_type_t types[8];
    types = '{BT_TERM0, BT_TERM1, BT_TERM2, BT_TERM3, BT_TERM4, BT_TERM5, BT_TERM6, BT_TERM7};
    return types[k];
endfunction

// One sync header through the lock rules
task automatic lock_header(input sync_hdr_t hdr);
    logic good;
    good = (hdr == 2'b01) || (hdr == 2'b10);
    case (m_state)
        LS_HUNT: begin
            m_good = good ? m_good + 1 : 0;
            if (!good) begin
                exp_slip = 1'b1;
                m_state  = LS_SLIP_WAIT;
                m_win    = 0;
            end else if (m_good == LOCK_GOOD_HDRS) begin
                m_state = LS_LOCKED;
                m_win   = 0;
                m_bad   = 0;
            end
        end
        LS_SLIP_WAIT: begin
            m_win = m_win + 1;
            if (m_win == SLIP_WAIT_HDRS) begin
                m_state = LS_HUNT;
                m_good  = 0;
            end
        end
        default: begin
            m_win = m_win + 1;
            m_bad = m_bad + (good ? 0 : 1);
            if (m_bad == UNLOCK_BAD_HDRS) begin
                exp_slip = 1'b1;
                m_state  = LS_SLIP_WAIT;
                m_win    = 0;
            end else if (m_win == 64) begin
                m_win = 0;
                m_bad = 0;
            end
        end
    endcase
    exp_slips = exp_slips + exp_slip;
    exp_lock  = (m_state == LS_LOCKED);
endtask

// Builds one block and queues its two expected XGMII words
task automatic model_block(input blk_kind_e kind, input int k,
                           output logic [63:0] blk, output sync_hdr_t hdr);
    logic [63:0] xd;
    logic [7:0]  xc;
    logic [7:0]  xt;
    blk = {$random(seed), $random(seed)};
    hdr = 2'b10;
    xc  = 8'h00;
    xt  = 8'h00;
    case (kind)
        K_DATA: hdr = 2'b01;
        K_IDLE: blk = {56'h0, BT_IDLE};
        K_START: blk[7:0] = BT_START;
        K_TERM: begin
            // Idle codes past the terminate, byte 4 zero in T4 to T7
            for (int b = 1; b < 8; b++) begin
                if (b > k || (b == 4 && k >= 4)) begin
                    blk[b*8 +: 8] = 8'h00;
                end
            end
            blk[7:0] = term_type(k);
        end
        K_BAD_TYPE: blk[7:0] = 8'h4B;
        default: hdr = k[0] ? 2'b11 : 2'b00;
    endcase
    xd = blk;
    if (kind >= K_BAD_TYPE) begin
        xd = {8{RS_ERROR}};
        xc = 8'hFF;
    end else if (kind == K_IDLE) begin
        xd = {8{RS_IDLE}};
        xc = 8'hFF;
    end else if (kind == K_START) begin
        xd[7:0] = RS_START;
        xc      = 8'h01;
    end else if (kind == K_TERM) begin
        for (int j = 0; j < 8; j++) begin
            xd[j*8 +: 8] = (j < k) ? blk[(j+1)*8 +: 8] : ((j == k) ? RS_TERM : RS_IDLE);
            xc[j]        = (j >= k);
            xt[j]        = (j == k);
        end
    end
    for (int w = 0; w < 2; w++) begin
        exp_data_q.push_back(xd[w*32 +: 32]);
        exp_ctl_q.push_back(xc[w*4 +: 4]);
        exp_term_q.push_back(xt[w*4 +: 4]);
    end
endtask

`endif

/* tests/tb_pcs_rx.sv */
`timescale 1ns/100ps

module tb_pcs_rx;

    import pcs_rx_pkg::*;

    logic        i_xver_rx_clk;
    logic        i_rx_reset;
    xgmii_data_t i_xver_rx_data;
    sync_hdr_t   i_xver_rx_header;
    logic        i_xver_rx_data_valid;
    logic        i_xver_rx_header_valid;
    logic        o_xver_rx_gearbox_slip;
    logic        o_block_lock;
    err_count_t  o_errored_blocks;
    xgmii_data_t o_xgmii_rx_data;
    xgmii_ctl_t  o_xgmii_rx_ctl;
    logic        o_xgmii_rx_valid;
    xgmii_ctl_t  o_term_loc;

    integer seed;
    int     test_errs;
    int     tests_failed;
    int     slips_seen;

    `include "pcs_rx_model.svh"

    pcs_rx #(.SCRAMBLER_BYPASS(1'b0)) dut_i (.*);

    initial begin
        i_xver_rx_clk = 1'b0;
        forever #50 i_xver_rx_clk = ~i_xver_rx_clk;
    end

    task automatic check_data(input string name, input xgmii_data_t got, input xgmii_data_t exp);
        if (got !== exp) begin
            $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
            test_errs++;
        end
    endtask

    task automatic check_ctl(input string name, input xgmii_ctl_t got, input xgmii_ctl_t exp);
        if (got !== exp) begin
            $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
            test_errs++;
        end
    endtask

    task automatic check_count(input string name, input err_count_t got, input err_count_t exp);
        if (got !== exp) begin
            $display("FAIL %0t %s got %0d expected %0d", $time, name, got, exp);
            test_errs++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
            test_errs++;
        end
    endtask

    // Checks what the last cycle produced, then drives the next word
    task automatic drive_cycle(input logic dv, input logic hv, input xgmii_data_t data,
                               input sync_hdr_t hdr);
        @(negedge i_xver_rx_clk);
        check_flag("o_xver_rx_gearbox_slip", o_xver_rx_gearbox_slip, exp_slip);
        check_flag("o_block_lock", o_block_lock, exp_lock);
        if (o_xver_rx_gearbox_slip === 1'b1) begin
            slips_seen++;
        end
        if (o_xgmii_rx_valid === 1'b1) begin
            if (exp_data_q.size() == 0) begin
                $display("Unexpected output word from the DUT at %0t", $time);
                test_errs++;
            end else begin
                check_data("o_xgmii_rx_data", o_xgmii_rx_data, exp_data_q.pop_front());
                check_ctl("o_xgmii_rx_ctl", o_xgmii_rx_ctl, exp_ctl_q.pop_front());
                check_ctl("o_term_loc", o_term_loc, exp_term_q.pop_front());
            end
        end else begin
            check_ctl("o_term_loc", o_term_loc, 4'h0);
        end
        i_xver_rx_data         = data;
        i_xver_rx_header       = hdr;
        i_xver_rx_data_valid   = dv;
        i_xver_rx_header_valid = hv;
        exp_slip               = 1'b0;
        if (hv) begin
            lock_header(hdr);
        end
    endtask

    // Gearbox pause with junk on the bus
    task automatic idle_cycle();
        drive_cycle(1'b0, 1'b0, xgmii_data_t'($random(seed)), sync_hdr_t'($random(seed)));
    endtask

    task automatic send_block(input blk_kind_e kind, input int k);
        logic [63:0] blk;
        sync_hdr_t   hdr;
        xgmii_data_t w0;
        xgmii_data_t w1;
        model_block(kind, k, blk, hdr);
        scramble_word(blk[31:0], w0);
        scramble_word(blk[63:32], w1);
        if ({$random(seed)} % 8 == 0) begin
            idle_cycle();
        end
        drive_cycle(1'b1, 1'b1, w0, hdr);
        // Counted when lock still holds after its own header
        if (kind >= K_BAD_TYPE && exp_lock && exp_errs != 8'hFF) begin
            exp_errs++;
        end
        if ({$random(seed)} % 8 == 0) begin
            idle_cycle();
        end
        drive_cycle(1'b1, 1'b0, w1, sync_hdr_t'($random(seed)));
    endtask

    task automatic send_good();
        int r;
        r = {$random(seed)} % 12;
        case (r)
            0, 1, 2, 3: send_block(K_DATA, 0);
            4: send_block(K_IDLE, 0);
            5: send_block(K_START, 0);
            default: send_block(K_TERM, {$random(seed)} % 8);
        endcase
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (exp_data_q.size() != 0 && n < 50) begin
            idle_cycle();
            n++;
        end
        if (exp_data_q.size() != 0) begin
            $display("Timeout waiting for %0d words from the DUT", exp_data_q.size());
            test_errs++;
        end
        // Error count settles one cycle after the last word
        idle_cycle();
        idle_cycle();
        check_count("o_errored_blocks", o_errored_blocks, exp_errs);
    endtask

    task automatic end_test(input int num, input string name);
        drain();
        check_count("slip pulses", err_count_t'(slips_seen), err_count_t'(exp_slips));
        if (test_errs == 0) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            $display("test %0d %s: %0d errors", num, name, test_errs);
            tests_failed++;
        end
        test_errs  = 0;
        slips_seen = 0;
        exp_slips  = 0;
    endtask

    initial begin
        int         n;
        err_count_t held;
        seed                   = 32'h4bb6;
        i_rx_reset             = 1'b1;
        i_xver_rx_data         = '0;
        i_xver_rx_header       = '0;
        i_xver_rx_data_valid   = 1'b0;
        i_xver_rx_header_valid = 1'b0;
        test_errs              = 0;
        tests_failed           = 0;
        slips_seen             = 0;
        model_reset();
        repeat (5) @(posedge i_xver_rx_clk);
        @(negedge i_xver_rx_clk);
        i_rx_reset = 1'b0;
        check_flag("o_xgmii_rx_valid", o_xgmii_rx_valid, 1'b0);
        check_count("o_errored_blocks", o_errored_blocks, 8'd0);

        // Header 11 throughout so slips come spaced by the wait window
        for (int i = 0; i < 40; i++) begin
            send_block(K_BAD_HDR, 1);
        end
        end_test(1, "hunt_and_slip");

        n = 0;
        while (o_block_lock !== 1'b1 && n < 200) begin
            send_good();
            n++;
        end
        if (o_block_lock !== 1'b1) begin
            $display("Timeout waiting for block lock");
            test_errs++;
        end
        end_test(2, "lock_acquisition");

        for (int i = 0; i < 500; i++) begin
            send_good();
        end
        end_test(3, "decode_with_pauses");

        for (int k = 0; k < 8; k++) begin
            for (int r = 0; r < 4; r++) begin
                send_block(K_TERM, k);
                send_block(K_DATA, 0);
            end
        end
        end_test(4, "terminate_location");

        for (int i = 0; i < 10; i++) begin
            if (i % 2 == 0) begin
                send_block(K_BAD_HDR, i / 2);
            end else begin
                send_block(K_BAD_TYPE, 0);
            end
            send_good();
        end
        drain();
        check_count("o_errored_blocks", o_errored_blocks, 8'd10);
        end_test(5, "errored_blocks");

        // Start on a fresh 64-header window
        n = 0;
        while (m_win != 0 && n < 80) begin
            send_block(K_DATA, 0);
            n++;
        end
        if (m_win != 0) begin
            $display("Timeout waiting for the start of a header window");
            test_errs++;
        end
        for (int i = 0; i < 16; i++) begin
            send_block(K_BAD_HDR, i);
            send_block(K_DATA, 0);
        end
        drain();
        held = exp_errs;
        for (int i = 0; i < 6; i++) begin
            send_block(K_BAD_TYPE, 0);
            send_good();
        end
        drain();
        check_flag("o_block_lock", o_block_lock, 1'b0);
        check_count("slip pulses", err_count_t'(slips_seen), 8'd1);
        check_count("o_errored_blocks", o_errored_blocks, held);
        end_test(6, "loss_of_lock");

        $display("6 tests run, %0d passed, %0d failed", 6 - tests_failed, tests_failed);
        if (tests_failed == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* pcs_rx.f */
+incdir+tests
src/pcs_rx_pkg.sv
src/pcs_rx_lock_state.sv
src/pcs_rx_descrambler.sv
src/pcs_rx_decoder.sv
src/pcs_rx_block_err_counter.sv
src/pcs_rx.sv
tests/tb_pcs_rx.sv

/* Bender.yml */
package:
  name: pcs_rx

sources:
  - src/pcs_rx_pkg.sv
  - src/pcs_rx_lock_state.sv
  - src/pcs_rx_descrambler.sv
  - src/pcs_rx_decoder.sv
  - src/pcs_rx_block_err_counter.sv
  - src/pcs_rx.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_pcs_rx.sv
